//--- verilog/video_pkg.sv
package video_pkg;

    // ------------------------------------------------------------------------
    // raster timing
    // ------------------------------------------------------------------------
    localparam int H_ACTIVE     = 16;                   // visible pixels per line
    localparam int H_TOTAL      = 24;                   // clocks per line
    localparam int H_SYNC_START = 18;                   // first hsync column
    localparam int H_SYNC_END   = 20;                   // last hsync column
    localparam int V_ACTIVE     = 8;                    // visible lines per frame
    localparam int V_TOTAL      = 12;                   // lines per frame
    localparam int V_SYNC_START = 9;                    // first vsync line
    localparam int V_SYNC_END   = 10;                   // last vsync line
    localparam int SYNC_DELAY   = 2;                    // counter state to pins

    localparam int H_CNT_W      = $clog2(H_TOTAL);      // column counter width
    localparam int V_CNT_W      = $clog2(V_TOTAL);      // line counter width
    localparam int H_ADDR_W     = $clog2(H_ACTIVE);     // column bits of address
    localparam int V_ADDR_W     = $clog2(V_ACTIVE);     // line bits of address

    // ------------------------------------------------------------------------
    // frame store geometry
    // ------------------------------------------------------------------------
    localparam int STORE_DEPTH  = H_ACTIVE * V_ACTIVE;  // one full frame
    localparam int STORE_AW     = V_ADDR_W + H_ADDR_W;  // {line, column}
    localparam int PIX_W        = 16;                   // rgb565 word

    typedef struct packed {
        logic [7:0] hi;                                 // first byte off the sensor
        logic [7:0] lo;                                 // second byte
    } pix_bytes_t;

    typedef struct packed {
        logic [4:0] r;                                  // top bits
        logic [5:0] g;
        logic [4:0] b;
    } pix_rgb565_t;

    // same 16 bits, seen as the sensor byte pair or as colour fields
    typedef union packed {
        pix_bytes_t  bytes;
        pix_rgb565_t rgb565;
    } pixel_word_t;

endpackage

//--- verilog/camera_byte_pack.sv
`timescale 1ns/1ps

module camera_byte_pack (
    input  logic                           video_clk,
    input  logic                           rst_n,
    input  logic                           cam_vsync,  // frame start on rising edge
    input  logic                           cam_href,   // byte valid
    input  logic [7:0]                     cam_data,
    output logic                           wr_en,
    output logic [video_pkg::STORE_AW-1:0] wr_addr,
    output video_pkg::pixel_word_t         wr_data
);

    logic                           vsync_q;     // previous vsync
    logic                           href_q;      // previous href
    logic                           byte_phase;  // 0 = expecting high byte
    logic                           frame_full;  // whole frame already written
    logic [video_pkg::STORE_AW-1:0] wr_ptr;      // next store address
    logic [7:0]                     hi_byte;     // held first byte of the pair
    logic                           vsync_rise;
    logic                           href_fall;
    logic                           pair_done;   // low byte arriving now
    logic                           pair_store;  // pair goes to the store
    video_pkg::pixel_word_t         rx_word;     // pair as received

    assign vsync_rise = cam_vsync & ~vsync_q;
    assign href_fall  = ~cam_href & href_q;
    assign pair_done  = cam_href & byte_phase & ~vsync_rise;
    assign pair_store = pair_done & ~frame_full;  // drop pairs past a full frame

    // assemble through the byte view
    always_comb
    begin
        rx_word.bytes.hi = hi_byte;
        rx_word.bytes.lo = cam_data;
    end

    // ------------------------------------------------------------------------
    // edge detect, byte phase and write pointer
    // ------------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vsync_q    <= 1'b0;
            href_q     <= 1'b0;
            byte_phase <= 1'b0;
            frame_full <= 1'b0;
            wr_ptr     <= '0;
            wr_en      <= 1'b0;
        end
        else
        begin
            vsync_q <= cam_vsync;
            href_q  <= cam_href;
            wr_en   <= pair_store;                        // write lands one cycle later
            if (vsync_rise)
            begin
                byte_phase <= 1'b0;                       // new frame, restart at 0
                frame_full <= 1'b0;
                wr_ptr     <= '0;
            end
            else if (cam_href)
            begin
                byte_phase <= ~byte_phase;
                if (pair_store)
                begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (wr_ptr == video_pkg::STORE_AW'(video_pkg::STORE_DEPTH - 1))
                    begin
                        frame_full <= 1'b1;               // last word of the frame
                    end
                end
            end
            else if (href_fall)
            begin
                byte_phase <= 1'b0;                       // unpaired trailing byte dropped
            end
        end
    end

    // ------------------------------------------------------------------------
    // payload, red and blue exchanged on the way out
    // ------------------------------------------------------------------------
    always_ff @(posedge video_clk)
    begin
        if (cam_href && !byte_phase)
        begin
            hi_byte <= cam_data;
        end
        if (pair_store)
        begin
            wr_addr           <= wr_ptr;
            wr_data.rgb565.r  <= rx_word.rgb565.b;
            wr_data.rgb565.g  <= rx_word.rgb565.g;
            wr_data.rgb565.b  <= rx_word.rgb565.r;
        end
    end

endmodule

//--- verilog/frame_store.sv
`timescale 1ns/1ps

module frame_store (
    input  logic                           video_clk,
    input  logic                           wr_en,
    input  logic [video_pkg::STORE_AW-1:0] wr_addr,
    input  logic [video_pkg::PIX_W-1:0]    wr_data,
    input  logic [video_pkg::STORE_AW-1:0] rd_addr,  // from raster, every cycle
    output logic [video_pkg::PIX_W-1:0]    rd_data   // one cycle after rd_addr
);

    // one frame of rgb565, {line, column} addressed
    logic [video_pkg::PIX_W-1:0] mem [video_pkg::STORE_DEPTH];

    // capture side
    always_ff @(posedge video_clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // display side, registered read
    // a same-cycle write shows up on the next read
    always_ff @(posedge video_clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- verilog/raster_timing.sv
`timescale 1ns/1ps

module raster_timing (
    input  logic                           video_clk,
    input  logic                           rst_n,
    output logic                           hs_raw,   // decoded from current count
    output logic                           vs_raw,
    output logic                           de_raw,
    output logic [video_pkg::STORE_AW-1:0] rd_addr
);

    logic [video_pkg::H_CNT_W-1:0] h_cnt;   // column
    logic [video_pkg::V_CNT_W-1:0] v_cnt;   // line
    logic                          h_last;  // last clock of the line
    logic                          v_last;  // last line of the frame

    assign h_last = (h_cnt == video_pkg::H_CNT_W'(video_pkg::H_TOTAL - 1));
    assign v_last = (v_cnt == video_pkg::V_CNT_W'(video_pkg::V_TOTAL - 1));

    // ------------------------------------------------------------------------
    // free running counters
    // ------------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;                              // restart at column 0, line 0
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;      // wrap at end of frame
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // sync windows and active area
    // ------------------------------------------------------------------------
    assign hs_raw = (h_cnt >= video_pkg::H_CNT_W'(video_pkg::H_SYNC_START)) &&
                    (h_cnt <= video_pkg::H_CNT_W'(video_pkg::H_SYNC_END));     // 3 columns
    assign vs_raw = (v_cnt >= video_pkg::V_CNT_W'(video_pkg::V_SYNC_START)) &&
                    (v_cnt <= video_pkg::V_CNT_W'(video_pkg::V_SYNC_END));     // 2 lines
    assign de_raw = (h_cnt < video_pkg::H_CNT_W'(video_pkg::H_ACTIVE)) &&
                    (v_cnt < video_pkg::V_CNT_W'(video_pkg::V_ACTIVE));

    // line*16 + column, parked at 0 in blanking
    assign rd_addr = de_raw ? {v_cnt[video_pkg::V_ADDR_W-1:0],
                               h_cnt[video_pkg::H_ADDR_W-1:0]} : '0;

endmodule

//--- verilog/video_out_stage.sv
`timescale 1ns/1ps

module video_out_stage (
    input  logic                   video_clk,
    input  logic                   rst_n,
    input  logic                   hs_raw,
    input  logic                   vs_raw,
    input  logic                   de_raw,
    input  video_pkg::pixel_word_t rd_data,  // one cycle behind the raw syncs
    output logic                   vid_hs,
    output logic                   vid_vs,
    output logic                   vid_de,
    output logic [7:0]             vid_r,
    output logic [7:0]             vid_g,
    output logic [7:0]             vid_b
);

    // {hs, vs, de} per stage, stage 0 is the once-delayed copy
    logic [video_pkg::SYNC_DELAY-1:0][2:0] sync_pipe;
    logic                                  de_early;  // de lined up with rd_data

    assign de_early = sync_pipe[video_pkg::SYNC_DELAY-2][0];

    // ------------------------------------------------------------------------
    // sync delay
    // ------------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_pipe <= '0;                          // all syncs low in reset
        end
        else
        begin
            sync_pipe <= {sync_pipe[video_pkg::SYNC_DELAY-2:0], {hs_raw, vs_raw, de_raw}};
        end
    end

    assign vid_hs = sync_pipe[video_pkg::SYNC_DELAY-1][2];
    assign vid_vs = sync_pipe[video_pkg::SYNC_DELAY-1][1];
    assign vid_de = sync_pipe[video_pkg::SYNC_DELAY-1][0];

    // ------------------------------------------------------------------------
    // blanking and 565 to 888, zero padded low bits
    // ------------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vid_r <= '0;
            vid_g <= '0;
            vid_b <= '0;
        end
        else if (de_early)
        begin
            vid_r <= {rd_data.rgb565.r, 3'b000};
            vid_g <= {rd_data.rgb565.g, 2'b00};
            vid_b <= {rd_data.rgb565.b, 3'b000};
        end
        else
        begin
            vid_r <= '0;                              // black outside active area
            vid_g <= '0;
            vid_b <= '0;
        end
    end

endmodule

//--- verilog/camera_display_top.sv
`timescale 1ns/1ps

module camera_display_top (
    input  logic       video_clk,
    input  logic       rst_n,
    input  logic       cam_vsync,
    input  logic       cam_href,
    input  logic [7:0] cam_data,
    output logic       vid_hs,
    output logic       vid_vs,
    output logic       vid_de,
    output logic [7:0] vid_r,
    output logic [7:0] vid_g,
    output logic [7:0] vid_b
);

    logic                           wr_en;    // capture write strobe
    logic [video_pkg::STORE_AW-1:0] wr_addr;
    logic [video_pkg::PIX_W-1:0]    wr_data;  // already red/blue swapped
    logic [video_pkg::STORE_AW-1:0] rd_addr;  // raster read address
    logic [video_pkg::PIX_W-1:0]    rd_data;
    logic                           hs_raw;
    logic                           vs_raw;
    logic                           de_raw;

    // ------------------------------------------------------------------------
    // sensor side
    // ------------------------------------------------------------------------
    camera_byte_pack u_byte_pack (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .cam_data  (cam_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    frame_store u_store (
        .video_clk (video_clk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // ------------------------------------------------------------------------
    // display side
    // ------------------------------------------------------------------------
    raster_timing u_raster (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .hs_raw    (hs_raw),
        .vs_raw    (vs_raw),
        .de_raw    (de_raw),
        .rd_addr   (rd_addr)
    );

    video_out_stage u_out (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .hs_raw    (hs_raw),
        .vs_raw    (vs_raw),
        .de_raw    (de_raw),
        .rd_data   (rd_data),
        .vid_hs    (vid_hs),
        .vid_vs    (vid_vs),
        .vid_de    (vid_de),
        .vid_r     (vid_r),
        .vid_g     (vid_g),
        .vid_b     (vid_b)
    );

endmodule

//--- bench/camera_display_props.sv
`timescale 1ns/1ps

module camera_display_props (
    input logic       video_clk,
    input logic       rst_n,
    input logic       vid_hs,
    input logic       vid_de,
    input logic [7:0] vid_r,
    input logic [7:0] vid_g,
    input logic [7:0] vid_b
);

    // black whenever the active flag is low
    blank_colour: assert property (@(posedge video_clk) disable iff (!rst_n)
        !vid_de |-> (vid_r == 8'h00 && vid_g == 8'h00 && vid_b == 8'h00))
        else $error("colour not blank while vid_de is low");

    // hsync window lies in horizontal blanking
    de_outside_hsync: assert property (@(posedge video_clk) disable iff (!rst_n)
        !(vid_de && vid_hs))
        else $error("vid_de high during hsync");

    hs_low_after_reset: assert property (@(posedge video_clk) $rose(rst_n) |-> !vid_hs)
        else $error("vid_hs high in the cycle after reset release");

endmodule

bind camera_display_top camera_display_props props (
    .video_clk (video_clk),
    .rst_n     (rst_n),
    .vid_hs    (vid_hs),
    .vid_de    (vid_de),
    .vid_r     (vid_r),
    .vid_g     (vid_g),
    .vid_b     (vid_b)
);

//--- bench/tb_camera_display.sv
`timescale 1ns/1ps

module tb_camera_display;

    localparam int MAX_CYCLES = 4000;           // ~12 frames of 288 plus capture

    logic       video_clk;
    logic       rst_n;
    logic       cam_vsync;
    logic       cam_href;
    logic [7:0] cam_data;
    logic       vid_hs;
    logic       vid_vs;
    logic       vid_de;
    logic [7:0] vid_r;
    logic [7:0] vid_g;
    logic [7:0] vid_b;

    int          errors;
    int          checks;
    int          cycle_cnt;
    logic [31:0] lfsr;                          // byte source
    logic        colour_check_en;               // model store settled
    logic [15:0] model_mem [video_pkg::STORE_DEPTH];
    logic [video_pkg::STORE_AW-1:0] model_ptr;
    logic        model_phase;                   // 1 = high byte held
    logic        model_full;
    logic [7:0]  model_hi;
    int          m_h;                           // model column
    int          m_v;                           // model line
    int          hist_h [2];                    // counter state, two cycles deep
    int          hist_v [2];
    logic [1:0]  hist_ok;                       // stage holds a post-reset state

    camera_display_top dut (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .cam_data  (cam_data),
        .vid_hs    (vid_hs),
        .vid_vs    (vid_vs),
        .vid_de    (vid_de),
        .vid_r     (vid_r),
        .vid_g     (vid_g),
        .vid_b     (vid_b)
    );

    initial
    begin
        video_clk = 1'b0;
        forever #20 video_clk = ~video_clk;     // 40 ns period
    end

    task automatic compare(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual)
        begin
            errors++;
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        logic       fb;
        int         i;
        b = '0;
        for (i = 0; i < 8; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            b    = {b[6:0], fb};
        end
        return b;
    endfunction

    // sensor order is {r5, g6, b5}, the store keeps {b5, g6, r5}
    function automatic logic [15:0] swap_red_blue(input logic [7:0] hi, input logic [7:0] lo);
        logic [15:0] w;
        w = {hi, lo};
        return {w[4:0], w[10:5], w[15:11]};
    endfunction

    // ------------------------------------------------------------------------
    // raster model and output checker
    // ------------------------------------------------------------------------
    always @(posedge video_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_h     <= 0;
            m_v     <= 0;
            hist_ok <= 2'b00;
        end
        else
        begin
            hist_h[1] <= hist_h[0];
            hist_v[1] <= hist_v[0];
            hist_h[0] <= m_h;
            hist_v[0] <= m_v;
            hist_ok   <= {hist_ok[0], 1'b1};
            if (m_h == video_pkg::H_TOTAL - 1)
            begin
                m_h <= 0;
                m_v <= (m_v == video_pkg::V_TOTAL - 1) ? 0 : m_v + 1;
            end
            else
            begin
                m_h <= m_h + 1;
            end
        end
    end

    always @(negedge video_clk)
    begin
        logic [15:0] px;
        int          de_exp;
        int          hs_exp;
        int          vs_exp;
        de_exp = (hist_ok[1] && hist_h[1] < video_pkg::H_ACTIVE &&
                  hist_v[1] < video_pkg::V_ACTIVE) ? 1 : 0;
        hs_exp = (hist_ok[1] && hist_h[1] >= video_pkg::H_SYNC_START &&
                  hist_h[1] <= video_pkg::H_SYNC_END) ? 1 : 0;
        vs_exp = (hist_ok[1] && hist_v[1] >= video_pkg::V_SYNC_START &&
                  hist_v[1] <= video_pkg::V_SYNC_END) ? 1 : 0;
        compare("vid_de", de_exp, int'(vid_de));
        compare("vid_hs", hs_exp, int'(vid_hs));
        compare("vid_vs", vs_exp, int'(vid_vs));
        if (de_exp == 0)
        begin
            compare("vid_r", 0, int'(vid_r));   // blanking
            compare("vid_g", 0, int'(vid_g));
            compare("vid_b", 0, int'(vid_b));
        end
        else if (colour_check_en)
        begin
            px = model_mem[video_pkg::STORE_AW'(hist_v[1] * video_pkg::H_ACTIVE + hist_h[1])];
            compare("vid_r", int'({px[15:11], 3'b000}), int'(vid_r));
            compare("vid_g", int'({px[10:5], 2'b00}), int'(vid_g));
            compare("vid_b", int'({px[4:0], 3'b000}), int'(vid_b));
        end
    end

    // ------------------------------------------------------------------------
    // sensor stimulus
    // ------------------------------------------------------------------------
    task automatic step();
        @(posedge video_clk);
        #2;                                     // drive just after the edge
    endtask

    task automatic model_byte(input logic [7:0] b);
        if (!model_phase)
        begin
            model_hi    = b;
            model_phase = 1'b1;
        end
        else
        begin
            model_phase = 1'b0;
            if (!model_full)
            begin
                model_mem[model_ptr] = swap_red_blue(model_hi, b);
                if (model_ptr == video_pkg::STORE_AW'(video_pkg::STORE_DEPTH - 1))
                begin
                    model_full = 1'b1;          // rest of the frame discarded
                end
                model_ptr = model_ptr + 1'b1;
            end
        end
    endtask

    task automatic send_vsync();
        step();
        cam_vsync = 1'b1;
        step();
        step();
        cam_vsync   = 1'b0;
        model_ptr   = '0;                       // frame restarts at address 0
        model_phase = 1'b0;
        model_full  = 1'b0;
        step();
    endtask

    task automatic send_line(input int n_bytes);
        logic [7:0] b;
        int         i;
        for (i = 0; i < n_bytes; i++)
        begin
            b        = random_byte();
            cam_href = 1'b1;
            cam_data = b;
            model_byte(b);
            step();
        end
        cam_href    = 1'b0;
        model_phase = 1'b0;                     // odd trailing byte dropped
        step();
        step();
    endtask

    task automatic start_capture();
        colour_check_en = 1'b0;                 // store changing under the raster
        send_vsync();
    endtask

    task automatic settle_store();
        repeat (4) step();
        colour_check_en = 1'b1;
    endtask

    task automatic wait_frame_start();
        @(negedge video_clk);
        while (!(hist_ok[1] && hist_h[1] == 0 && hist_v[1] == 0))
        begin
            @(negedge video_clk);
        end
    endtask

    // n whole display frames pass with colour checking on
    task automatic hold_frames(input int n);
        repeat (n + 1) wait_frame_start();
        step();                                 // back on the drive edge
    endtask

    initial
    begin
        int first_de;
        int line;
        errors          = 0;
        checks          = 0;
        rst_n           = 1'b0;
        cam_vsync       = 1'b0;
        cam_href        = 1'b0;
        cam_data        = 8'h00;
        colour_check_en = 1'b0;
        model_ptr       = '0;
        model_phase     = 1'b0;
        model_full      = 1'b0;
        model_hi        = 8'h00;
        lfsr            = 32'hda2d;
        repeat (8) @(posedge video_clk);
        #2;
        rst_n    = 1'b1;
        first_de = 0;
        while (vid_de == 1'b0 && first_de < 10)
        begin
            @(posedge video_clk);
            first_de++;
            @(negedge video_clk);
        end
        compare("cycles to first vid_de", 2, first_de);

        // full random frame, two display frames checked
        start_capture();
        for (line = 0; line < video_pkg::V_ACTIVE; line++)
        begin
            send_line(2 * video_pkg::H_ACTIVE);
        end
        settle_store();
        hold_frames(2);

        // odd byte at the end of line 2
        start_capture();
        for (line = 0; line < video_pkg::V_ACTIVE; line++)
        begin
            send_line((line == 2) ? 33 : 32);
        end
        settle_store();
        hold_frames(1);

        // 150 pairs, only 128 kept
        start_capture();
        for (line = 0; line < 9; line++)
        begin
            send_line(32);
        end
        send_line(12);
        settle_store();
        hold_frames(1);

        // vsync in mid-frame after 3 lines
        start_capture();
        for (line = 0; line < 3; line++)
        begin
            send_line(32);
        end
        send_vsync();
        send_line(32);
        send_line(32);
        settle_store();
        hold_frames(1);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES)
        begin
            @(posedge video_clk);
            cycle_cnt++;
        end
        $display("timeout: stimulus still running after %0d cycles", MAX_CYCLES);
        $display("checks %0d, errors %0d", checks, errors);
        $display("Errors found");
        $finish;
    end

endmodule

//--- filelist.f
verilog/video_pkg.sv
verilog/camera_byte_pack.sv
verilog/frame_store.sv
verilog/raster_timing.sv
verilog/video_out_stage.sv
verilog/camera_display_top.sv
bench/camera_display_props.sv
bench/tb_camera_display.sv

//--- run_sim.sh
#!/bin/sh
# build and run the camera display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_camera_display \
    -f filelist.f -o tb_camera_display
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_camera_display +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
